// ==== src/ipod_pkg.sv ====
package ipod_pkg;

  // ====================
  // Data widths
  // ====================
  typedef logic signed [15:0] sample_t;      // One audio sample
  typedef logic [7:0]         audio_byte_t;  // Upper byte of a sample
  typedef logic [31:0]        flash_word_t;  // Low half plays first going forward
  typedef logic [22:0]        flash_addr_t;  // Word address
  typedef logic [19:0]        divisor_t;     // Sample period in CLK_50M cycles
  typedef logic [7:0]         ascii_t;
  typedef logic [6:0]         seg_t;         // Active low, bit 6 is segment g

  // ====================
  // Control bundles
  // ====================

  // One-cycle pulses from the buttons
  typedef struct packed {
    logic faster;
    logic slower;
    logic restore;
  } speed_cmd_t;

  // Playback state from the keyboard
  typedef struct packed {
    logic playing;  // Level
    logic forward;  // Level
    logic restart;  // One-cycle pulse
  } play_ctrl_t;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_DATA,
    SECOND_HALF
  } read_state_t;

  // ====================
  // Constants
  // ====================
  localparam divisor_t MIN_DIVISOR = 20'd8;

  localparam ascii_t CMD_PLAY     = 8'h45;  // E
  localparam ascii_t CMD_PAUSE    = 8'h44;  // D
  localparam ascii_t CMD_FORWARD  = 8'h46;  // F
  localparam ascii_t CMD_BACKWARD = 8'h42;  // B
  localparam ascii_t CMD_RESTART  = 8'h52;  // R

  // Clears bit 5 so lower case maps onto upper case
  localparam ascii_t CASE_MASK = 8'hDF;

endpackage

// ==== src/player_input.sv ====
`timescale 1ns/1ps

module player_input import ipod_pkg::*; #(
  parameter int KEY_REPEAT_CYCLES = 5000000
) (
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [2:0] key,        // Active low buttons
  input  ascii_t     kbd_ascii,
  input  logic       kbd_valid,
  output speed_cmd_t speed_cmd,
  output play_ctrl_t play_ctrl
);

  localparam int CNT_W = $clog2(KEY_REPEAT_CYCLES + 1);
  localparam logic [CNT_W-1:0] RPT_LAST = CNT_W'(KEY_REPEAT_CYCLES - 1);

  logic [2:0]       key_s1;
  logic [2:0]       key_s2;      // Synced, high when pressed
  logic [2:0]       key_q;       // Previous synced state
  logic [CNT_W-1:0] rpt_cnt [2];
  logic [1:0]       rpt_fire;

  logic   kbd_valid_s1;
  ascii_t kbd_char_s1;
  ascii_t kbd_char;

  // ====================
  // Buttons
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_s1 <= '0;
      key_s2 <= '0;
      key_q  <= '0;
    end
    else
    begin
      key_s1 <= ~key;
      key_s2 <= key_s1;
      key_q  <= key_s2;
    end
  end

  // Fire on the press edge, then once per repeat period while held
  always_comb
  begin
    for (int i = 0; i < 2; i++)
      rpt_fire[i] = key_s2[i] && (!key_q[i] || rpt_cnt[i] == RPT_LAST);
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rpt_cnt[0] <= '0;
      rpt_cnt[1] <= '0;
    end
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        if (!key_s2[i] || rpt_fire[i])
          rpt_cnt[i] <= '0;
        else
          rpt_cnt[i] <= rpt_cnt[i] + 1'b1;
      end
    end
  end

  assign speed_cmd.faster  = rpt_fire[0];
  assign speed_cmd.slower  = rpt_fire[1];
  assign speed_cmd.restore = key_s2[2] & ~key_q[2];  // Once per press

  // ====================
  // Keyboard commands
  // ====================

  // Character captured with its strobe
  always_ff @(posedge CLK_50M)
  begin
    if (kbd_valid)
      kbd_char_s1 <= kbd_ascii;
  end

  assign kbd_char = kbd_char_s1 & CASE_MASK;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      kbd_valid_s1      <= 1'b0;
      play_ctrl.playing <= 1'b0;
      play_ctrl.forward <= 1'b1;
      play_ctrl.restart <= 1'b0;
    end
    else
    begin
      kbd_valid_s1      <= kbd_valid;
      play_ctrl.restart <= 1'b0;
      if (kbd_valid_s1)
      begin
        case (kbd_char)
          CMD_PLAY:     play_ctrl.playing <= 1'b1;
          CMD_PAUSE:    play_ctrl.playing <= 1'b0;
          CMD_FORWARD:  play_ctrl.forward <= 1'b1;
          CMD_BACKWARD: play_ctrl.forward <= 1'b0;
          CMD_RESTART:  play_ctrl.restart <= 1'b1;
          default:      ;  // Other keys do nothing
        endcase
      end
    end
  end

endmodule

// ==== src/sample_rate_gen.sv ====
`timescale 1ns/1ps

module sample_rate_gen import ipod_pkg::*; #(
  parameter divisor_t DEFAULT_DIVISOR = 20'd2272,
  parameter divisor_t DIVISOR_STEP    = 20'd16
) (
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  speed_cmd_t speed_cmd,
  input  logic       playing,
  output divisor_t   divisor,
  output logic       sample_tick
);

  localparam divisor_t MAX_DIVISOR = '1;

  divisor_t period_cnt;
  divisor_t next_divisor;
  logic     speed_change;

  assign speed_change = speed_cmd.faster | speed_cmd.slower | speed_cmd.restore;

  // Restore wins over the step buttons
  always_comb
  begin
    next_divisor = divisor;
    if (speed_cmd.restore)
      next_divisor = DEFAULT_DIVISOR;
    else if (speed_cmd.faster)
      next_divisor = (divisor < MIN_DIVISOR + DIVISOR_STEP) ? MIN_DIVISOR
                                                            : divisor - DIVISOR_STEP;
    else if (speed_cmd.slower)
      next_divisor = (divisor > MAX_DIVISOR - DIVISOR_STEP) ? MAX_DIVISOR
                                                            : divisor + DIVISOR_STEP;
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      divisor <= DEFAULT_DIVISOR;
    else
      divisor <= next_divisor;
  end

  // Period counter, held at zero while paused
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      period_cnt  <= '0;
      sample_tick <= 1'b0;
    end
    else if (!playing || speed_change)
    begin
      period_cnt  <= '0;
      sample_tick <= 1'b0;
    end
    else if (period_cnt == divisor - divisor_t'(1))
    begin
      period_cnt  <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      period_cnt  <= period_cnt + divisor_t'(1);
      sample_tick <= 1'b0;
    end
  end

endmodule

// ==== src/flash_reader.sv ====
`timescale 1ns/1ps

module flash_reader import ipod_pkg::*; #(
  parameter flash_addr_t LAST_WORD_ADDR = 23'h7FFFF
) (
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  play_ctrl_t  play_ctrl,
  input  logic        sample_tick,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output logic        flash_read,
  output flash_addr_t flash_address,
  output sample_t     sample,
  output logic        sample_strobe
);

  read_state_t state;
  flash_addr_t word_addr;
  flash_addr_t step_addr;
  flash_word_t word_q;
  logic        half_hi;    // Half that plays next
  logic        pending;    // One tick held while a read is busy
  logic        drop;       // Aborted read still owes a data pulse
  logic        go;
  logic        take;
  logic        in_flight;

  function automatic sample_t pick_half(flash_word_t word, logic hi);
    sample_t s;
    s = hi ? word[31:16] : word[15:0];
    return s;
  endfunction

  assign flash_read    = (state == REQUEST);
  assign flash_address = word_addr;

  assign go        = sample_tick | pending;
  assign in_flight = (state == REQUEST) | ((state == WAIT_DATA) & ~flash_readdatavalid);

  // SECOND_HALF needs no read, IDLE has to wait for a stale read to drain
  assign take = go & ((state == SECOND_HALF) | ((state == IDLE) & ~drop));

  // Next word in play direction with wrap at both ends
  always_comb
  begin
    if (play_ctrl.forward)
      step_addr = (word_addr == LAST_WORD_ADDR) ? '0 : word_addr + 1'b1;
    else
      step_addr = (word_addr == '0) ? LAST_WORD_ADDR : word_addr - 1'b1;
  end

  // ====================
  // Read FSM
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state         <= IDLE;
      word_addr     <= '0;
      half_hi       <= 1'b0;
      pending       <= 1'b0;
      drop          <= 1'b0;
      sample        <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      sample_strobe <= 1'b0;
      if (drop && flash_readdatavalid)
        drop <= 1'b0;

      if (play_ctrl.restart)
      begin
        state     <= IDLE;
        pending   <= 1'b0;
        drop      <= in_flight | (drop & ~flash_readdatavalid);
        word_addr <= play_ctrl.forward ? '0 : LAST_WORD_ADDR;
        half_hi   <= ~play_ctrl.forward;  // Backward starts on the high half
      end
      else
      begin
        if (!play_ctrl.playing || take)
          pending <= 1'b0;
        else if (sample_tick)
          pending <= 1'b1;

        case (state)
          IDLE:
          begin
            if (take)
              state <= REQUEST;
          end
          REQUEST:
            state <= WAIT_DATA;
          WAIT_DATA:
          begin
            if (flash_readdatavalid)
            begin
              sample        <= pick_half(flash_readdata, half_hi);
              sample_strobe <= 1'b1;
              half_hi       <= ~half_hi;
              state         <= SECOND_HALF;
            end
          end
          SECOND_HALF:
          begin
            if (take)
            begin
              sample        <= pick_half(word_q, half_hi);
              sample_strobe <= 1'b1;
              word_addr     <= step_addr;
              half_hi       <= ~play_ctrl.forward;
              state         <= IDLE;
            end
          end
          default:
            state <= IDLE;
        endcase
      end
    end
  end

  // Word kept for its second half
  always_ff @(posedge CLK_50M)
  begin
    if (state == WAIT_DATA && flash_readdatavalid)
      word_q <= flash_readdata;
  end

endmodule

// ==== src/player_output.sv ====
`timescale 1ns/1ps

module player_output import ipod_pkg::*; (
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  divisor_t    divisor,
  input  sample_t     sample,
  input  logic        sample_strobe,
  input  play_ctrl_t  play_ctrl,
  output seg_t        hex0,
  output seg_t        hex1,
  output seg_t        hex2,
  output seg_t        hex3,
  output seg_t        hex4,
  output seg_t        hex5,
  output logic [9:0]  led,
  output audio_byte_t audio_out
);

  audio_byte_t top_byte;
  audio_byte_t magnitude;
  logic [7:0]  level;
  logic [7:0]  level_bar;

  // Shared hex digit table
  function automatic seg_t hex_to_seg(logic [3:0] nib);
    seg_t seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  // ====================
  // Divisor display
  // ====================
  assign hex0 = hex_to_seg(divisor[3:0]);
  assign hex1 = hex_to_seg(divisor[7:4]);
  assign hex2 = hex_to_seg(divisor[11:8]);
  assign hex3 = hex_to_seg(divisor[15:12]);
  assign hex4 = hex_to_seg(divisor[19:16]);
  assign hex5 = 7'h7F;  // Blank

  // Level meter
  assign top_byte  = sample[15:8];
  assign magnitude = top_byte[7] ? audio_byte_t'(-top_byte) : top_byte;  // -128 reads as 128

  always_comb
  begin
    for (int i = 0; i < 8; i++)
      level[i] = magnitude > audio_byte_t'(16 * i);
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      audio_out <= '0;
      level_bar <= '0;
    end
    else if (sample_strobe)
    begin
      audio_out <= top_byte;
      level_bar <= level;
    end
  end

  assign led = {play_ctrl.playing, play_ctrl.forward, level_bar};

endmodule

// ==== src/simple_ipod_top.sv ====
`timescale 1ns/1ps

module simple_ipod_top import ipod_pkg::*; #(
  parameter int          KEY_REPEAT_CYCLES = 5000000,  // 10 repeats per second
  parameter divisor_t    DEFAULT_DIVISOR   = 20'd2272, // About 22 kHz
  parameter divisor_t    DIVISOR_STEP      = 20'd16,
  parameter flash_addr_t LAST_WORD_ADDR    = 23'h7FFFF
) (
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  logic [2:0]  key,
  input  ascii_t      kbd_ascii,
  input  logic        kbd_valid,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output logic        flash_read,
  output flash_addr_t flash_address,
  output sample_t     sample,
  output logic        sample_strobe,
  output audio_byte_t audio_out,
  output seg_t        hex0,
  output seg_t        hex1,
  output seg_t        hex2,
  output seg_t        hex3,
  output seg_t        hex4,
  output seg_t        hex5,
  output logic [9:0]  led
);

  speed_cmd_t speed_cmd;
  play_ctrl_t play_ctrl;
  divisor_t   divisor;
  logic       sample_tick;

  player_input #(
    .KEY_REPEAT_CYCLES (KEY_REPEAT_CYCLES)
  ) u_player_input (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .key       (key),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .speed_cmd (speed_cmd),
    .play_ctrl (play_ctrl)
  );

  sample_rate_gen #(
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR),
    .DIVISOR_STEP    (DIVISOR_STEP)
  ) u_sample_rate_gen (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .speed_cmd   (speed_cmd),
    .playing     (play_ctrl.playing),
    .divisor     (divisor),
    .sample_tick (sample_tick)
  );

  flash_reader #(
    .LAST_WORD_ADDR (LAST_WORD_ADDR)
  ) u_flash_reader (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .play_ctrl           (play_ctrl),
    .sample_tick         (sample_tick),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .sample              (sample),
    .sample_strobe       (sample_strobe)
  );

  player_output u_player_output (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .divisor       (divisor),
    .sample        (sample),
    .sample_strobe (sample_strobe),
    .play_ctrl     (play_ctrl),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5),
    .led           (led),
    .audio_out     (audio_out)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,  // ns
  parameter int RESET_CYCLES = 2
) (
  output logic CLK_50M,
  output logic arst_n
);

  initial
  begin
    CLK_50M = 1'b0;
    forever #(HALF_PERIOD) CLK_50M = ~CLK_50M;
  end

  // Released on a falling edge, away from the DUT's sampling edge
  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK_50M);
    @(negedge CLK_50M);
    arst_n = 1'b1;
  end

endmodule

// ==== sim/tb_simple_ipod.sv ====
`timescale 1ns/1ps

module tb_simple_ipod import ipod_pkg::*; ();

  localparam int          KEY_REPEAT    = 40;
  localparam divisor_t    DEF_DIVISOR   = 20'd64;
  localparam divisor_t    STEP          = 20'd4;
  localparam flash_addr_t LAST_ADDR     = 23'd5;
  localparam divisor_t    FLOOR_DIVISOR = 20'd8;
  localparam int          SHORT_HOLD    = 10;   // Below one repeat period
  localparam int          LONG_HOLD     = (64 - 8) / 4 * KEY_REPEAT + 2 * KEY_REPEAT;
  localparam int          STROBE_WAIT   = 4 * 64;
  // Tests need about 4000 cycles at a 64 cycle sample period
  localparam int          TIMEOUT_CYCLES = 20000;

  logic        CLK_50M;
  logic        arst_n;
  logic [2:0]  key;
  ascii_t      kbd_ascii;
  logic        kbd_valid;
  flash_word_t flash_readdata      = '0;
  logic        flash_readdatavalid = 1'b0;
  logic        flash_read;
  flash_addr_t flash_address;
  sample_t     sample;
  logic        sample_strobe;
  audio_byte_t audio_out;
  seg_t        hex0, hex1, hex2, hex3, hex4, hex5;
  logic [9:0]  led;

  int   errors = 0;
  int   checks = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  int   cycles;
  int   exp_addr;  // Expected position of the next sample
  logic exp_hi;
  logic exp_fwd;
  logic exp_play;

  tb_clock_gen clock_gen (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n)
  );

  simple_ipod_top #(
    .KEY_REPEAT_CYCLES (KEY_REPEAT),
    .DEFAULT_DIVISOR   (DEF_DIVISOR),
    .DIVISOR_STEP      (STEP),
    .LAST_WORD_ADDR    (LAST_ADDR)
  ) DUT (
    .CLK_50M (CLK_50M), .arst_n (arst_n), .key (key),
    .kbd_ascii (kbd_ascii), .kbd_valid (kbd_valid),
    .flash_readdata (flash_readdata), .flash_readdatavalid (flash_readdatavalid),
    .flash_read (flash_read), .flash_address (flash_address),
    .sample (sample), .sample_strobe (sample_strobe), .audio_out (audio_out),
    .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3), .hex4 (hex4), .hex5 (hex5),
    .led (led)
  );

  // ====================
  // Flash model
  // ====================
  logic [31:0] lfsr = 32'h11e11862;
  logic [1:0]  lat_bits;
  int          read_wait = 0;
  flash_addr_t read_addr;

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic flash_word_t word_at(flash_addr_t a);
    return {8'h80 + a[7:0], 8'hB0, a[7:0], 8'h10};
  endfunction

  always @(negedge CLK_50M)
  begin
    flash_readdatavalid = 1'b0;
    if (read_wait > 0)
    begin
      read_wait = read_wait - 1;
      if (read_wait == 0)
      begin
        flash_readdata      = word_at(read_addr);
        flash_readdatavalid = 1'b1;
      end
    end
    if (flash_read)
    begin
      if (read_wait != 0)
      begin
        $display("Flash read issued while another read was still outstanding");
        errors++;
      end
      lfsr        = lfsr_step(lfsr);
      lat_bits[0] = lfsr[0];
      lfsr        = lfsr_step(lfsr);
      lat_bits[1] = lfsr[0];
      read_wait   = 1 + lat_bits;  // 1 to 4 cycles
      read_addr   = flash_address;
    end
  end

  // Watchdog
  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge CLK_50M);
      cycles++;
    end
    $display("Timeout, run still busy after %0d cycles", cycles);
    $display("=== FAIL ===");
    $finish;
  end

  // ====================
  // Helpers
  // ====================
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // Digits the tests display, segments g..a lit, then inverted
  function automatic seg_t seg_of(logic [3:0] nib);
    logic [6:0] lit;
    case (nib)
      4'h0: lit = 7'b0111111;
      4'h3: lit = 7'b1001111;
      4'h4: lit = 7'b1100110;
      4'h8: lit = 7'b1111111;
      default: lit = 7'b0000000;
    endcase
    return ~lit;
  endfunction

  function automatic sample_t expected_sample(int a, logic hi);
    logic [7:0] ab;
    ab = a[7:0];
    if (hi)
      return {8'h80 + ab, 8'hB0};
    return {ab, 8'h10};
  endfunction

  // Bar bit i lit when the byte's magnitude is above 16 * i
  function automatic logic [7:0] level_bits(logic [7:0] b);
    int         mag;
    logic [7:0] bits;
    mag = b[7] ? 256 - int'(b) : int'(b);
    for (int i = 0; i < 8; i++)
      bits[i] = mag > 16 * i;
    return bits;
  endfunction

  task automatic check_display(input divisor_t d);
    check("hex0", hex0, seg_of(d[3:0]));
    check("hex1", hex1, seg_of(d[7:4]));
    check("hex2", hex2, seg_of(d[11:8]));
    check("hex3", hex3, seg_of(d[15:12]));
    check("hex4", hex4, seg_of(d[19:16]));
    check("hex5", hex5, 7'h7F);
  endtask

  task automatic send_char(input ascii_t c);
    @(negedge CLK_50M);
    kbd_ascii = c;
    kbd_valid = 1'b1;
    @(negedge CLK_50M);
    kbd_valid = 1'b0;
  endtask

  task automatic press_key(input int idx, input int hold);
    @(negedge CLK_50M);
    key[idx] = 1'b0;
    repeat (hold) @(negedge CLK_50M);
    key[idx] = 1'b1;
    repeat (4) @(negedge CLK_50M);  // Synchronizer drains
  endtask

  task automatic expect_quiet(input int n);
    int hits;
    hits = 0;
    repeat (n)
    begin
      @(negedge CLK_50M);
      if (flash_read || sample_strobe)
        hits++;
    end
    if (hits != 0)
    begin
      $display("Flash read or sample strobe seen in %0d of %0d quiet cycles", hits, n);
      errors++;
    end
  endtask

  task automatic wait_strobe(output logic seen);
    int n;
    n = 0;
    @(negedge CLK_50M);
    while (!sample_strobe && n < STROBE_WAIT)
    begin
      @(negedge CLK_50M);
      n++;
    end
    seen = sample_strobe;
    if (!seen)
    begin
      $display("No sample strobe within %0d cycles", STROBE_WAIT);
      errors++;
    end
  endtask

  // Next half in play order, word step with wrap after the second half
  task automatic advance_position();
    if (exp_hi == !exp_fwd)
      exp_hi = !exp_hi;
    else
    begin
      if (exp_fwd)
        exp_addr = (exp_addr == LAST_ADDR) ? 0 : exp_addr + 1;
      else
        exp_addr = (exp_addr == 0) ? int'(LAST_ADDR) : exp_addr - 1;
      exp_hi = !exp_fwd;
    end
  endtask

  task automatic expect_samples(input int n);
    sample_t exp_s;
    logic    seen;
    for (int i = 0; i < n; i++)
    begin
      wait_strobe(seen);
      if (!seen)
        return;
      exp_s = expected_sample(exp_addr, exp_hi);
      check("sample", sample, exp_s);
      @(negedge CLK_50M);  // Outputs follow one cycle later
      check("audio_out", audio_out, exp_s[15:8]);
      check("led", led, {exp_play, exp_fwd, level_bits(exp_s[15:8])});
      advance_position();
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("Test %-18s ok", name);
    else
    begin
      tests_failed++;
      $display("Test %-18s failed with %0d errors", name, errors - err_before);
    end
  endtask

  // ====================
  // Tests
  // ====================
  task automatic test_reset_state();
    int err0;
    err0 = errors;
    check_display(DEF_DIVISOR);
    check("led", led, 10'h100);  // Forward lamp only
    expect_quiet(50);
    finish_test("reset_state", err0);
  endtask

  task automatic test_forward_play();
    int err0;
    err0 = errors;
    exp_addr = 0;
    exp_hi   = 1'b0;
    exp_fwd  = 1'b1;
    exp_play = 1'b1;
    send_char(CMD_PLAY);
    expect_samples(14);  // Past the wrap from word 5 to word 0
    finish_test("forward_play", err0);
  endtask

  task automatic test_backward_restart();
    int err0;
    err0 = errors;
    send_char(CMD_BACKWARD);
    send_char(CMD_RESTART);
    exp_addr = LAST_ADDR;
    exp_hi   = 1'b1;
    exp_fwd  = 1'b0;
    expect_samples(14);
    finish_test("backward_restart", err0);
  endtask

  task automatic test_pause();
    int err0;
    err0 = errors;
    send_char(CMD_PAUSE);
    exp_play = 1'b0;
    expect_quiet(300);
    check("led[9]", led[9], 1'b0);
    send_char(CMD_PLAY);
    exp_play = 1'b1;
    expect_samples(2);  // Resumes where it stopped
    finish_test("pause", err0);
  endtask

  task automatic test_speed_buttons();
    int err0;
    err0 = errors;
    send_char(CMD_PAUSE);
    exp_play = 1'b0;
    repeat (2) press_key(0, SHORT_HOLD);
    check_display(DEF_DIVISOR - 2 * STEP);
    repeat (3) press_key(1, SHORT_HOLD);
    check_display(DEF_DIVISOR + STEP);
    press_key(2, SHORT_HOLD);
    check_display(DEF_DIVISOR);
    press_key(0, LONG_HOLD);  // Repeats run into the floor
    check_display(FLOOR_DIVISOR);
    press_key(2, SHORT_HOLD);
    check_display(DEF_DIVISOR);
    finish_test("speed_buttons", err0);
  endtask

  task automatic test_keyboard_case();
    int err0;
    err0 = errors;
    check("led[8]", led[8], 1'b0);
    send_char(8'h66);  // f
    repeat (2) @(negedge CLK_50M);
    check("led[8]", led[8], 1'b1);
    send_char(CMD_RESTART);
    send_char(8'h65);  // e
    exp_addr = 0;
    exp_hi   = 1'b0;
    exp_fwd  = 1'b1;
    exp_play = 1'b1;
    expect_samples(4);
    finish_test("keyboard_case", err0);
  endtask

  initial
  begin
    key       = 3'b111;  // Released
    kbd_ascii = '0;
    kbd_valid = 1'b0;
    exp_addr  = 0;
    exp_hi    = 1'b0;
    exp_fwd   = 1'b1;
    exp_play  = 1'b0;
    @(posedge arst_n);
    @(negedge CLK_50M);
    test_reset_state();
    test_forward_play();
    test_backward_restart();
    test_pause();
    test_speed_buttons();
    test_keyboard_case();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== src.f ====
src/ipod_pkg.sv
src/player_input.sv
src/sample_rate_gen.sv
src/flash_reader.sv
src/player_output.sv
src/simple_ipod_top.sv
sim/tb_clock_gen.sv
sim/tb_simple_ipod.sv

// ==== Bender.yml ====
package:
  name: simple_ipod

sources:
  - files:
      - src/ipod_pkg.sv
      - src/player_input.sv
      - src/sample_rate_gen.sv
      - src/flash_reader.sv
      - src/player_output.sv
      - src/simple_ipod_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_simple_ipod.sv
